// File: bench/program_patterns.hex
# I word: program in order from pc 0; D addr word: initial data memory
# S addr data be: expected store, data masked by byte_en; E flag: final mal_fault
I 10000093  addi x1, x0, 256
I 12345137  lui x2, 0x12345
I 67810113  addi x2, x2, 0x678
I 0020a023  sw x2, 0(x1)
I 00001197  auipc x3, 1
I ffb00213  addi x4, x0, -5
I 404182b3  sub x5, x3, x4
I 0050a223  sw x5, 4(x1)
I 40125313  srai x6, x4, 1
I 0060a423  sw x6, 8(x1)
I 004143b3  xor x7, x2, x4
I 0070a623  sw x7, 12(x1)
I 022081a3  sb x2, 35(x1)
I 022080a3  sb x2, 33(x1)
I 02209223  sh x2, 36(x1)
I 02209323  sh x2, 38(x1)
I 20000413  addi x8, x0, 512
I 00140483  lb x9, 1(x8)
I 00344503  lbu x10, 3(x8)
I 00241583  lh x11, 2(x8)
I 00045603  lhu x12, 0(x8)
I 0290a823  sw x9, 48(x1)
I 02a0aa23  sw x10, 52(x1)
I 02b0ac23  sw x11, 56(x1)
I 02c0ae23  sw x12, 60(x1)
I 00b48463  beq x9, x11, +8 not taken
I 0420a023  sw x2, 64(x1)
I 00a4c463  blt x9, x10, +8 taken
I 0400a223  sw x0, 68(x1) skipped
I 00a4f463  bgeu x9, x10, +8 taken
I 0400a423  sw x0, 72(x1) skipped
I 008007ef  jal x15, +8
I 0400a623  sw x0, 76(x1) skipped
I 04f0a823  sw x15, 80(x1)
I 00000897  auipc x17, 0
I 00d88867  jalr x16, 13(x17)
I 0400aa23  sw x0, 84(x1) skipped
I 0500ac23  sw x16, 88(x1)
I 0020a123  sw x2, 2(x1) misaligned
I 0420ae23  sw x2, 92(x1) never reached
I 00100073  ebreak
D 00000200 8091a2f3
S 00000100 12345678 f
S 00000104 00001015 f
S 00000108 fffffffd f
S 0000010c edcba983 f
S 00000123 78000000 8
S 00000121 00007800 2
S 00000124 00005678 3
S 00000126 56780000 c
S 00000130 ffffffa2 f
S 00000134 00000080 f
S 00000138 ffff8091 f
S 0000013c 0000a2f3 f
S 00000140 12345678 f
S 00000150 00000080 f
S 00000158 00000090 f
E 1

// File: bench/tb_tspp_core.sv
// two-stage core testbench with clock, reset, memories, pattern loading, checks and timeout
`timescale 1ns/10ps

module tb_tspp_core;
    import tspp_pkg::*;

    logic      CLK = 1'b0;
    logic      nRST;
    word_t     imem_addr;
    word_t     imem_rdata;
    dbus_req_t dbus;
    word_t     drdata;
    logic      dbusy = 1'b0;
    logic      halt;
    logic      mal_fault;

    word_t       imem [256];
    word_t       dmem [256];
    word_t       exp_addr [$];
    word_t       exp_data [$];
    logic [3:0]  exp_be [$];
    word_t       exp_mal;
    int          num_instr;
    int          store_idx = 0;
    int          cycles;
    int          limit;

    // busy generator state
    logic [31:0] lfsr = 32'h2552141c;
    logic [1:0]  busy_left = 2'd0;
    logic        waiting = 1'b0;

    tspp_core #(
        .RESET_PC(32'h0000_0000)
    ) u_tspp_core (
        .CLK,
        .nRST,
        .imem_addr,
        .imem_rdata,
        .dbus,
        .drdata,
        .dbusy,
        .halt,
        .mal_fault
    );

    always #5 CLK = ~CLK;

    // both memories answer in the same cycle
    assign imem_rdata = imem[imem_addr[9:2]];
    assign drdata = dmem[dbus.addr[9:2]];

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic word_t lane_mask(input logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("ERROR: %s is %h, expected %h", name, got, expected));
        end
    endtask

    task automatic load_patterns();
        int    fd;
        int    code;
        int    n;
        int    want;
        string line;
        byte   tag;
        word_t a;
        word_t d;
        word_t be;
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h0;
            dmem[i] = 32'h9e3779b9 * 32'(i + 1);
        end
        num_instr = 0;
        exp_mal = 32'h0;
        fd = $fopen("bench/program_patterns.hex", "r");
        if (fd == 0) begin
            stop_with_failure("could not open bench/program_patterns.hex");
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            n = 0;
            want = 0;
            tag = (code > 0) ? line.getc(0) : 8'h0;
            case (tag)
                "I": begin
                    n = $sscanf(line, "I %h", d);
                    want = 1;
                    imem[num_instr] = d;
                    num_instr++;
                end
                "D": begin
                    n = $sscanf(line, "D %h %h", a, d);
                    want = 2;
                    dmem[a[9:2]] = d;
                end
                "S": begin
                    n = $sscanf(line, "S %h %h %h", a, d, be);
                    want = 3;
                    exp_addr.push_back(a);
                    exp_data.push_back(d);
                    exp_be.push_back(be[3:0]);
                end
                "E": begin
                    n = $sscanf(line, "E %h", exp_mal);
                    want = 1;
                end
                default: ;
            endcase
            if (n != want) begin
                stop_with_failure($sformatf("malformed pattern line: %s", line));
            end
        end
        $fclose(fd);
    endtask

    // 0 to 3 busy cycles per access from two lfsr bits drawn at its start
    always @(posedge CLK) begin
        #1;
        if (dbus.ren || dbus.wen) begin
            if (!waiting) begin
                lfsr = lfsr_next(lfsr);
                busy_left[0] = lfsr[0];
                lfsr = lfsr_next(lfsr);
                busy_left[1] = lfsr[0];
            end else begin
                busy_left = busy_left - 2'd1;
            end
            waiting = (busy_left != 2'd0);
            dbusy = waiting;
        end else begin
            waiting = 1'b0;
            dbusy = 1'b0;
        end
    end

    // mid-cycle sampling of the bus
    always @(negedge CLK) begin : bus_monitor
        logic [7:0] idx;
        if (!nRST) begin
            check_value("dbus.ren", 32'(dbus.ren), 32'h0);
            check_value("dbus.wen", 32'(dbus.wen), 32'h0);
            check_value("imem_addr", imem_addr, 32'h0);
        end
        // fetch stays word aligned, jalr targets included
        check_value("imem_addr[1:0]", 32'(imem_addr[1:0]), 32'h0);
        if (!nRST || store_idx == 0) begin
            check_value("halt", 32'(halt), 32'h0);
            check_value("mal_fault", 32'(mal_fault), 32'h0);
        end
        // accepting cycle of a store
        if (nRST && dbus.wen && !dbusy) begin
            if (store_idx >= exp_addr.size()) begin
                stop_with_failure($sformatf("unexpected store to address %h", dbus.addr));
            end else begin
                check_value("dbus.addr", dbus.addr, exp_addr[store_idx]);
                check_value("dbus.wdata", dbus.wdata & lane_mask(dbus.byte_en),
                            exp_data[store_idx]);
                check_value("dbus.byte_en", 32'(dbus.byte_en), 32'(exp_be[store_idx]));
                idx = dbus.addr[9:2];
                for (int b = 0; b < 4; b++) begin
                    if (dbus.byte_en[b]) begin
                        dmem[idx][8*b +: 8] = dbus.wdata[8*b +: 8];
                    end
                end
                store_idx++;
            end
        end
    end

    initial begin
        nRST = 1'b0;
        load_patterns();
        limit = num_instr * 8 + 50;
        repeat (2) @(posedge CLK);
        #1 nRST = 1'b1;
        cycles = 0;
        while (halt !== 1'b1) begin
            @(negedge CLK);
            cycles++;
            if (cycles > limit) begin
                stop_with_failure($sformatf("timeout: core did not halt within %0d cycles",
                                            limit));
            end
        end
        // a few more cycles to catch strobes after halt
        repeat (5) @(negedge CLK);
        check_value("store count", 32'(store_idx), 32'(exp_addr.size()));
        check_value("mal_fault", 32'(mal_fault), exp_mal);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: bench/tspp_core_asserts.sv
// concurrent data bus and halt assertions for the execute stage, with their bind
`timescale 1ns/10ps

module tspp_core_asserts (
    input logic                CLK,
    input logic                nRST,
    input tspp_pkg::dbus_req_t dbus,
    input logic                halt
);

    // a single access is either a read or a write
    assert property (@(posedge CLK) disable iff (!nRST) !(dbus.ren && dbus.wen))
        else $error("read and write strobes asserted together");

    assert property (@(posedge CLK) disable iff (!nRST)
        (dbus.ren || dbus.wen) |-> (dbus.byte_en != 4'b0000))
        else $error("bus strobe with no byte enabled");

    // halt is sticky until reset
    assert property (@(posedge CLK) disable iff (!nRST) !$fell(halt))
        else $error("halt dropped without reset");

    assert property (@(posedge CLK) disable iff (!nRST)
        halt |-> !(dbus.ren || dbus.wen))
        else $error("bus strobe while halted");

endmodule

bind tspp_execute_stage tspp_core_asserts u_core_asserts (
    .CLK(CLK),
    .nRST(nRST),
    .dbus(dbus),
    .halt(halt)
);

// File: build.f
verilog/tspp_pkg.sv
verilog/tspp_fetch_stage.sv
verilog/control_unit.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/lsu_align.sv
verilog/tspp_execute_stage.sv
verilog/tspp_core.sv
bench/tspp_core_asserts.sv
bench/tb_tspp_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the two-stage core testbench with verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
        --top-module tb_tspp_core \
        -f build.f \
        -Mdir obj_dir -o sim_tspp_core; then
    echo "verilator build failed" >&2
    exit 1
fi

./obj_dir/sim_tspp_core
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status" >&2
    exit "$status"
fi

exit 0

// File: verilog/alu.sv
// integer alu and branch condition compare
`timescale 1ns/10ps

module alu (
    input  tspp_pkg::aluop_t  aluop,
    input  tspp_pkg::word_t   port_a,
    input  tspp_pkg::word_t   port_b,
    output tspp_pkg::word_t   port_out,
    input  tspp_pkg::branch_t branch_type,
    input  tspp_pkg::word_t   rs1_data,
    input  tspp_pkg::word_t   rs2_data,
    output logic              branch_taken
);
    import tspp_pkg::*;

    logic [4:0] shamt;

    assign shamt = port_b[4:0];

    always_comb begin
        case (aluop)
            ALU_ADD:  port_out = port_a + port_b;
            ALU_SUB:  port_out = port_a - port_b;
            ALU_SLL:  port_out = port_a << shamt;
            ALU_SLT:  port_out = {31'b0, $signed(port_a) < $signed(port_b)};
            ALU_SLTU: port_out = {31'b0, port_a < port_b};
            ALU_XOR:  port_out = port_a ^ port_b;
            ALU_SRL:  port_out = port_a >> shamt;
            ALU_SRA:  port_out = $signed(port_a) >>> shamt;
            ALU_OR:   port_out = port_a | port_b;
            default:  port_out = port_a & port_b;
        endcase
    end

    // branch compare always uses the raw register values
    always_comb begin
        case (branch_type)
            BEQ:     branch_taken = (rs1_data == rs2_data);
            BNE:     branch_taken = (rs1_data != rs2_data);
            BLT:     branch_taken = ($signed(rs1_data) < $signed(rs2_data));
            BGE:     branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
            BLTU:    branch_taken = (rs1_data < rs2_data);
            BGEU:    branch_taken = (rs1_data >= rs2_data);
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

// File: verilog/control_unit.sv
// rv32i instruction decoder producing the control struct and immediate
`timescale 1ns/10ps

module control_unit (
    input  tspp_pkg::word_t instr,
    output tspp_pkg::ctrl_t ctrl
);
    import tspp_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic       alt;
    aluop_t     f3_aluop;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    // funct7 bit 5 picks SUB and SRA
    assign alt = instr[30];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (funct3)
            3'b000:  f3_aluop = ALU_ADD;
            3'b001:  f3_aluop = ALU_SLL;
            3'b010:  f3_aluop = ALU_SLT;
            3'b011:  f3_aluop = ALU_SLTU;
            3'b100:  f3_aluop = ALU_XOR;
            3'b101:  f3_aluop = alt ? ALU_SRA : ALU_SRL;
            3'b110:  f3_aluop = ALU_OR;
            default: f3_aluop = ALU_AND;
        endcase
    end

    always_comb begin
        ctrl = '0;
        ctrl.rs1 = instr[19:15];
        ctrl.rs2 = instr[24:20];
        ctrl.rd = instr[11:7];
        ctrl.load_type = load_t'(funct3);
        ctrl.branch_type = branch_t'(funct3);
        ctrl.aluop = ALU_ADD;
        ctrl.asel = A_RS1;
        ctrl.bsel = B_IMM;
        ctrl.wsel = W_ALU;
        case (opcode)
            OP_LUI: begin
                ctrl.wen = 1'b1;
                ctrl.wsel = W_IMMU;
                ctrl.imm = imm_u;
            end
            OP_AUIPC: begin
                ctrl.wen = 1'b1;
                ctrl.asel = A_PC;
                ctrl.imm = imm_u;
            end
            OP_JAL, OP_JALR: begin
                ctrl.wen = 1'b1;
                ctrl.wsel = W_PC4;
                ctrl.jump = 1'b1;
                ctrl.j_sel = (opcode == OP_JAL);
                ctrl.imm = (opcode == OP_JAL) ? imm_j : imm_i;
            end
            OP_BRANCH: begin
                ctrl.branch = 1'b1;
                ctrl.j_sel = 1'b1;
                ctrl.imm = imm_b;
                ctrl.illegal = (funct3[2:1] == 2'b01);
            end
            OP_LOAD: begin
                ctrl.wen = 1'b1;
                ctrl.dren = 1'b1;
                ctrl.wsel = W_LOAD;
                ctrl.imm = imm_i;
                ctrl.illegal = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
            end
            OP_STORE: begin
                ctrl.dwen = 1'b1;
                ctrl.imm = imm_s;
                ctrl.illegal = funct3[2] || (funct3[1:0] == 2'b11);
            end
            OP_IMMED: begin
                ctrl.wen = 1'b1;
                ctrl.aluop = f3_aluop;
                ctrl.imm = imm_i;
            end
            OP_REGREG: begin
                ctrl.wen = 1'b1;
                ctrl.bsel = B_RS2;
                ctrl.aluop = (funct3 == 3'b000 && alt) ? ALU_SUB : f3_aluop;
            end
            // only EBREAK is known here
            OP_SYSTEM: begin
                ctrl.halt = (instr == 32'h0010_0073);
                ctrl.illegal = (instr != 32'h0010_0073);
            end
            default: ctrl.illegal = 1'b1;
        endcase
    end

endmodule

// File: verilog/lsu_align.sv
// byte enables, store replication, load extension and misalignment for the data bus
`timescale 1ns/10ps

module lsu_align (
    input  tspp_pkg::word_t addr,
    input  tspp_pkg::load_t load_type,
    input  tspp_pkg::word_t store_data,
    input  tspp_pkg::word_t rdata,
    output logic [3:0]      byte_en,
    output tspp_pkg::word_t wdata,
    output tspp_pkg::word_t load_ext,
    output logic            mal
);
    import tspp_pkg::*;

    logic [1:0]  offset;
    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    assign offset = addr[1:0];
    assign byte_lane = rdata[{offset, 3'b000} +: 8];
    assign half_lane = rdata[{offset[1], 4'b0000} +: 16];

    always_comb begin
        case (load_type)
            LB, LBU: begin
                byte_en = 4'b0001 << offset;
                wdata = {4{store_data[7:0]}};
                mal = 1'b0;
            end
            LH, LHU: begin
                byte_en = offset[1] ? 4'b1100 : 4'b0011;
                wdata = {2{store_data[15:0]}};
                mal = offset[0];
            end
            LW: begin
                byte_en = 4'b1111;
                wdata = store_data;
                mal = (offset != 2'b00);
            end
            default: begin
                byte_en = 4'b0000;
                wdata = store_data;
                mal = 1'b0;
            end
        endcase
    end

    // unsigned forms have funct3 bit 2 set
    always_comb begin
        case (load_type)
            LB:      load_ext = {{24{byte_lane[7]}}, byte_lane};
            LBU:     load_ext = {24'b0, byte_lane};
            LH:      load_ext = {{16{half_lane[15]}}, half_lane};
            LHU:     load_ext = {16'b0, half_lane};
            default: load_ext = rdata;
        endcase
    end

endmodule

// File: verilog/reg_file.sv
// 32-entry register file, two async read ports, one sync write port
`timescale 1ns/10ps

module reg_file (
    input  logic                CLK,
    input  logic                nRST,
    input  tspp_pkg::reg_addr_t rs1,
    input  tspp_pkg::reg_addr_t rs2,
    input  tspp_pkg::reg_addr_t rd,
    input  logic                wen,
    input  tspp_pkg::word_t     w_data,
    output tspp_pkg::word_t     rs1_data,
    output tspp_pkg::word_t     rs2_data
);
    import tspp_pkg::*;

    word_t regs [32];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != 5'd0) begin
            regs[rd] <= w_data;
        end
    end

    // x0 always reads as zero
    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: verilog/tspp_core.sv
// two-stage rv32i core top level joining fetch and execute
`timescale 1ns/10ps

module tspp_core #(
    parameter tspp_pkg::word_t RESET_PC = '0
) (
    input  logic                CLK,
    input  logic                nRST,
    output tspp_pkg::word_t     imem_addr,
    input  tspp_pkg::word_t     imem_rdata,
    output tspp_pkg::dbus_req_t dbus,
    input  tspp_pkg::word_t     drdata,
    input  logic                dbusy,
    output logic                halt,
    output logic                mal_fault
);
    import tspp_pkg::*;

    fetch_ex_t fetch_ex;
    logic      stall;
    logic      redirect;
    word_t     brj_addr;

    tspp_fetch_stage #(
        .RESET_PC(RESET_PC)
    ) u_fetch_stage (
        .CLK,
        .nRST,
        .stall,
        .redirect,
        .brj_addr,
        .imem_addr,
        .imem_rdata,
        .fetch_ex
    );

    tspp_execute_stage u_execute_stage (
        .CLK,
        .nRST,
        .fetch_ex,
        .stall,
        .redirect,
        .brj_addr,
        .dbus,
        .drdata,
        .dbusy,
        .halt,
        .mal_fault
    );

endmodule

// File: verilog/tspp_execute_stage.sv
// execute stage with decode, register file, alu, branch redirect, data bus and halt
`timescale 1ns/10ps

module tspp_execute_stage (
    input  logic                CLK,
    input  logic                nRST,
    input  tspp_pkg::fetch_ex_t fetch_ex,
    output logic                stall,
    output logic                redirect,
    output tspp_pkg::word_t     brj_addr,
    output tspp_pkg::dbus_req_t dbus,
    input  tspp_pkg::word_t     drdata,
    input  logic                dbusy,
    output logic                halt,
    output logic                mal_fault
);
    import tspp_pkg::*;

    ctrl_t      ctrl;
    word_t      rs1_data, rs2_data, w_data;
    word_t      port_a, port_b, alu_out;
    word_t      brj_base, brj_sum;
    word_t      store_wdata, load_ext;
    logic [3:0] byte_en;
    logic       branch_taken, mal;
    logic       live, mem_req, mal_access, busy_wait, advance, halt_r, mal_r;

    control_unit u_control_unit (.instr(fetch_ex.instr), .ctrl(ctrl));

    reg_file u_reg_file (
        .CLK, .nRST,
        .rs1(ctrl.rs1), .rs2(ctrl.rs2), .rd(ctrl.rd),
        .wen(advance & ctrl.wen & ~mal_access),
        .w_data, .rs1_data, .rs2_data
    );

    alu u_alu (
        .aluop(ctrl.aluop), .port_a, .port_b, .port_out(alu_out),
        .branch_type(ctrl.branch_type), .rs1_data, .rs2_data, .branch_taken
    );

    lsu_align u_lsu_align (
        .addr(alu_out), .load_type(ctrl.load_type), .store_data(rs2_data),
        .rdata(drdata), .byte_en, .wdata(store_wdata), .load_ext, .mal
    );

    assign port_a = (ctrl.asel == A_PC) ? fetch_ex.pc : rs1_data;
    assign port_b = (ctrl.bsel == B_RS2) ? rs2_data : ctrl.imm;

    always_comb begin
        case (ctrl.wsel)
            W_LOAD:  w_data = load_ext;
            W_PC4:   w_data = fetch_ex.pc4;
            W_IMMU:  w_data = ctrl.imm;
            default: w_data = alu_out;
        endcase
    end

    // jal and branches are pc relative, jalr drops bit 0
    assign brj_base = ctrl.j_sel ? fetch_ex.pc : rs1_data;
    assign brj_sum = brj_base + ctrl.imm;
    assign brj_addr = {brj_sum[31:1], brj_sum[0] & ctrl.j_sel};

    // live instruction in execute
    assign live = fetch_ex.valid & ~halt_r;
    assign mal_access = live & (ctrl.dren | ctrl.dwen) & mal;
    assign mem_req = live & (ctrl.dren | ctrl.dwen) & ~mal;
    assign busy_wait = mem_req & dbusy;
    assign advance = live & ~busy_wait;

    assign stall = halt_r | busy_wait;
    assign redirect = advance & (ctrl.jump | (ctrl.branch & branch_taken));

    assign dbus.ren = mem_req & ctrl.dren;
    assign dbus.wen = mem_req & ctrl.dwen;
    assign dbus.byte_en = byte_en;
    assign dbus.addr = alu_out;
    assign dbus.wdata = store_wdata;

    // both flags are sticky until reset
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            halt_r <= 1'b0;
            mal_r <= 1'b0;
        end else begin
            if (live & (ctrl.halt | ctrl.illegal | mal_access)) begin
                halt_r <= 1'b1;
            end
            if (mal_access) begin
                mal_r <= 1'b1;
            end
        end
    end

    assign halt = halt_r;
    assign mal_fault = mal_r;

endmodule

// File: verilog/tspp_fetch_stage.sv
// fetch stage with pc register, instruction fetch and fetch-to-execute register
`timescale 1ns/10ps

module tspp_fetch_stage #(
    parameter tspp_pkg::word_t RESET_PC = '0
) (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                stall,
    input  logic                redirect,
    input  tspp_pkg::word_t     brj_addr,
    output tspp_pkg::word_t     imem_addr,
    input  tspp_pkg::word_t     imem_rdata,
    output tspp_pkg::fetch_ex_t fetch_ex
);
    import tspp_pkg::*;

    word_t pc;
    word_t pc4;
    logic  valid_r;
    word_t instr_r;
    word_t pc_r;
    word_t pc4_r;

    assign pc4 = pc + 32'd4;
    assign imem_addr = pc;

    // redirect wins and flushes the wrong-path instruction
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc <= RESET_PC;
            valid_r <= 1'b0;
        end else if (redirect) begin
            pc <= brj_addr;
            valid_r <= 1'b0;
        end else if (!stall) begin
            pc <= pc4;
            valid_r <= 1'b1;
        end
    end

    // instruction payload follows the pc unless held or flushed
    always_ff @(posedge CLK) begin
        if (!redirect && !stall) begin
            instr_r <= imem_rdata;
            pc_r <= pc;
            pc4_r <= pc4;
        end
    end

    assign fetch_ex = '{instr: instr_r, pc: pc_r, pc4: pc4_r, valid: valid_r};

endmodule

// File: verilog/tspp_pkg.sv
// shared word, opcode, alu, load/branch and stage register types for the two-stage core
package tspp_pkg;

    parameter int WORD_W = 32;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [4:0] reg_addr_t;

    // major opcodes handled by the decoder
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMMED  = 7'b0010011,
        OP_REGREG = 7'b0110011,
        OP_SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } aluop_t;

    // funct3 encodings, taken straight from the instruction
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_t;

    // stores reuse LB/LH/LW for SB/SH/SW
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } load_t;

    typedef enum logic [1:0] {
        W_LOAD,
        W_PC4,
        W_IMMU,
        W_ALU
    } wsel_t;

    typedef enum logic [1:0] {
        A_RS1,
        A_PC
    } asel_t;

    typedef enum logic [1:0] {
        B_RS2,
        B_IMM
    } bsel_t;

    typedef struct packed {
        word_t instr;
        word_t pc;
        word_t pc4;
        logic  valid;
    } fetch_ex_t;

    typedef struct packed {
        aluop_t    aluop;
        asel_t     asel;
        bsel_t     bsel;
        wsel_t     wsel;
        load_t     load_type;
        branch_t   branch_type;
        logic      wen;
        logic      dren;
        logic      dwen;
        logic      branch;
        logic      jump;
        logic      j_sel;
        logic      halt;
        logic      illegal;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
    } ctrl_t;

    typedef struct packed {
        logic       ren;
        logic       wen;
        logic [3:0] byte_en;
        word_t      addr;
        word_t      wdata;
    } dbus_req_t;

endpackage
